// File: hw/uart_pkg.sv
////////////////////
// Serial link types
////////////////////

package uart_pkg;

	// One data byte on the wire, LSB goes first
	typedef logic [7:0] uart_byte_t;

	// Clocks counted inside one bit period
	typedef logic [15:0] baud_cnt_t;

	// Which of the eight data bits is on the line
	typedef logic [2:0] bit_idx_t;

endpackage

// File: hw/rpn_calc_pkg.sv
////////////////////
// Calculator types
////////////////////

package rpn_calc_pkg;

	// Operand and result width
	typedef logic [15:0] calc_word_t;

	// Opcode byte as sent by the host
	typedef enum logic [7:0] {
		op_push = 8'h01, // Followed by high and low data byte
		op_add  = 8'h02,
		op_sub  = 8'h03,
		op_mul  = 8'h04, // Low 16 bits only
		op_and  = 8'h05,
		op_or   = 8'h06,
		op_xor  = 8'h07,
		op_drop = 8'h08,
		op_swap = 8'h09
	} calc_op_e;

	// Command from frame assembler to ALU
	typedef struct packed {
		calc_op_e   op;
		calc_word_t operand; // Only meaningful for push
	} calc_cmd_t;

	// ALU status, order matches LED bits 3..0
	typedef struct packed {
		logic stack_error;
		logic carry;
		logic negative;
		logic zero;
	} calc_flags_t;

endpackage

// File: hw/uart_rx.sv
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; #(
	parameter int CLK_FREQUENCY = 100_000_000,
	parameter int BAUD_RATE     = 115200
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx,
	output uart_byte_t rx_data,
	output logic       rx_ready
);

	localparam baud_cnt_t BIT_LAST  = baud_cnt_t'(CLK_FREQUENCY / BAUD_RATE - 1);
	localparam baud_cnt_t HALF_LAST = baud_cnt_t'(CLK_FREQUENCY / BAUD_RATE / 2 - 1);

	typedef enum logic [1:0] {s_idle, s_start, s_data, s_stop} rx_state_e;

	rx_state_e  state;
	logic [1:0] rx_sync;  // Two flop synchronizer
	logic       rx_prev;  // For the falling start edge
	baud_cnt_t  cnt;
	bit_idx_t   bit_idx;
	uart_byte_t shift;
	logic       bit_end, half_end;

	assign bit_end  = (cnt == BIT_LAST);
	assign half_end = (cnt == HALF_LAST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_sync <= 2'b11; // Line idles high
			rx_prev <= 1'b1;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			rx_prev <= rx_sync[1];
		end
	end

	////////////////////
	// Bit timing FSM
	////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= s_idle;
			cnt      <= '0;
			bit_idx  <= '0;
			rx_ready <= 1'b0;
		end else begin
			rx_ready <= 1'b0; // Single cycle pulse
			case (state)
				s_idle: begin
					cnt     <= '0;
					bit_idx <= '0;
					if (rx_prev && !rx_sync[1])
						state <= s_start;
				end
				s_start: begin
					if (half_end) begin
						cnt   <= '0;
						state <= rx_sync[1] ? s_idle : s_data; // Glitch, not a start bit
					end else
						cnt <= cnt + 1'b1;
				end
				s_data: begin
					if (bit_end) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= s_stop;
					end else
						cnt <= cnt + 1'b1;
				end
				s_stop: begin
					if (bit_end) begin
						rx_ready <= rx_sync[1]; // Framing error drops the byte
						state    <= s_idle;
					end else
						cnt <= cnt + 1'b1;
				end
				default: state <= s_idle;
			endcase
		end
	end

	// Data path, LSB arrives first
	always_ff @(posedge clk) begin
		if (state == s_data && bit_end)
			shift <= {rx_sync[1], shift[7:1]};
		if (state == s_stop && bit_end)
			rx_data <= shift; // Valid together with rx_ready
	end

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; #(
	parameter int CLK_FREQUENCY = 100_000_000,
	parameter int BAUD_RATE     = 115200
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tx_start,
	input  uart_byte_t tx_data,
	output logic       tx,
	output logic       tx_busy
);

	localparam baud_cnt_t BIT_LAST = baud_cnt_t'(CLK_FREQUENCY / BAUD_RATE - 1);

	typedef enum logic [1:0] {s_idle, s_start, s_data, s_stop} tx_state_e;

	tx_state_e  state;
	baud_cnt_t  cnt;
	bit_idx_t   bit_idx;
	uart_byte_t shift; // Bit 0 is next on the line
	logic       bit_end;

	assign bit_end = (cnt == BIT_LAST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= s_idle;
			cnt     <= '0;
			bit_idx <= '0;
			tx      <= 1'b1; // Idle level
			tx_busy <= 1'b0;
		end else begin
			case (state)
				s_idle: if (tx_start) begin
					state   <= s_start;
					cnt     <= '0;
					tx      <= 1'b0; // Start bit
					tx_busy <= 1'b1;
				end
				s_start: if (bit_end) begin
					cnt     <= '0;
					bit_idx <= '0;
					tx      <= shift[0];
					state   <= s_data;
				end else
					cnt <= cnt + 1'b1;
				s_data: if (bit_end) begin
					cnt <= '0;
					if (bit_idx == 3'd7) begin
						tx    <= 1'b1; // Stop bit
						state <= s_stop;
					end else begin
						bit_idx <= bit_idx + 1'b1;
						tx      <= shift[1]; // Shift moves on this same edge
					end
				end else
					cnt <= cnt + 1'b1;
				s_stop: if (bit_end) begin
					tx_busy <= 1'b0; // Ten bit periods done
					state   <= s_idle;
				end else
					cnt <= cnt + 1'b1;
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_idle && tx_start)
			shift <= tx_data;
		else if (state == s_data && bit_end)
			shift <= shift >> 1;
	end

	// Result controller must honour busy
	assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
		else $error("tx_start while transmitter busy");

endmodule

// File: hw/rx_frame_ctrl.sv
`timescale 1ns/1ns

module rx_frame_ctrl import uart_pkg::*, rpn_calc_pkg::*; #(
	parameter int FRAME_TIMEOUT = 100_000
) (
	input  logic       clk,
	input  logic       rst_n,
	input  uart_byte_t rx_data,
	input  logic       rx_ready,
	output calc_cmd_t  cmd,
	output logic       cmd_valid,
	output logic [3:0] state
);

	localparam int TW = $clog2(FRAME_TIMEOUT + 1);

	// One hot so the LEDs read directly
	typedef enum logic [3:0] {
		s_idle      = 4'b0001,
		s_wait_high = 4'b0010,
		s_wait_low  = 4'b0100,
		s_emit      = 4'b1000
	} frame_state_e;

	frame_state_e fsm;
	logic [TW-1:0] timer; // Clocks since the last byte of a push
	logic          is_op, timed_out;

	assign is_op     = (rx_data >= op_add) && (rx_data <= op_swap); // Single byte ops
	assign timed_out = (timer == TW'(FRAME_TIMEOUT));
	assign cmd_valid = (fsm == s_emit); // One cycle after the last byte
	assign state     = fsm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fsm   <= s_idle;
			timer <= '0;
		end else begin
			case (fsm)
				s_idle: begin
					timer <= '0;
					if (rx_ready) begin
						if (rx_data == op_push)
							fsm <= s_wait_high;
						else if (is_op)
							fsm <= s_emit;
						// Unknown opcode just falls through
					end
				end
				s_wait_high: begin
					if (rx_ready) begin
						timer <= '0;
						fsm   <= s_wait_low;
					end else if (timed_out)
						fsm <= s_idle; // Abandoned frame
					else
						timer <= timer + 1'b1;
				end
				s_wait_low: begin
					if (rx_ready) begin
						timer <= '0;
						fsm   <= s_emit;
					end else if (timed_out)
						fsm <= s_idle;
					else
						timer <= timer + 1'b1;
				end
				s_emit:  fsm <= s_idle;
				default: fsm <= s_idle;
			endcase
		end
	end

	// Command fields fill in as bytes arrive
	always_ff @(posedge clk) begin
		if (rx_ready) begin
			case (fsm)
				s_idle:      cmd.op <= calc_op_e'(rx_data);
				s_wait_high: cmd.operand[15:8] <= rx_data;
				s_wait_low:  cmd.operand[7:0]  <= rx_data;
				default: ;
			endcase
		end
	end

endmodule

// File: hw/rpn_alu.sv
`timescale 1ns/1ns

module rpn_alu import rpn_calc_pkg::*; #(
	parameter int STACK_DEPTH = 4
) (
	input  logic        clk,
	input  logic        rst_n,
	input  calc_cmd_t   cmd,
	input  logic        cmd_valid,
	output calc_word_t  tos,
	output calc_flags_t flags,
	output logic        result_valid,
	output logic [2:0]  depth
);

	localparam int CW = $clog2(STACK_DEPTH + 1);

	calc_word_t    stack     [STACK_DEPTH]; // Entry 0 is top of stack
	calc_word_t    stack_nxt [STACK_DEPTH];
	logic [CW-1:0] count, count_nxt;
	calc_flags_t   flags_nxt;
	calc_word_t    tos_nxt;
	logic [16:0]   wide; // Bit 16 holds carry or borrow

	////////////////////
	// Next stack state
	////////////////////
	always_comb begin
		stack_nxt = stack;
		count_nxt = count;
		flags_nxt = '0;
		wide      = '0;
		case (cmd.op)
			op_push: begin
				for (int i = STACK_DEPTH - 1; i > 0; i--)
					stack_nxt[i] = stack[i-1]; // Bottom falls off when full
				stack_nxt[0] = cmd.operand;
				if (count != CW'(STACK_DEPTH))
					count_nxt = count + 1'b1;
			end
			op_add, op_sub, op_mul, op_and, op_or, op_xor: begin
				if (count < 2)
					flags_nxt.stack_error = 1'b1; // Stack left alone
				else begin
					case (cmd.op)
						op_add:  wide = {1'b0, stack[1]} + {1'b0, stack[0]};
						op_sub:  wide = {1'b0, stack[1]} - {1'b0, stack[0]};
						op_mul:  wide = {1'b0, stack[1] * stack[0]};
						op_and:  wide = {1'b0, stack[1] & stack[0]};
						op_or:   wide = {1'b0, stack[1] | stack[0]};
						default: wide = {1'b0, stack[1] ^ stack[0]};
					endcase
					flags_nxt.carry = wide[16]; // Zero for the non arithmetic ops
					stack_nxt[0] = wide[15:0];
					for (int i = 1; i < STACK_DEPTH - 1; i++)
						stack_nxt[i] = stack[i+1];
					stack_nxt[STACK_DEPTH-1] = '0;
					count_nxt = count - 1'b1;
				end
			end
			op_drop: begin
				if (count == '0)
					flags_nxt.stack_error = 1'b1;
				else begin
					for (int i = 0; i < STACK_DEPTH - 1; i++)
						stack_nxt[i] = stack[i+1];
					stack_nxt[STACK_DEPTH-1] = '0;
					count_nxt = count - 1'b1;
				end
			end
			op_swap: begin
				if (count < 2)
					flags_nxt.stack_error = 1'b1;
				else begin
					stack_nxt[0] = stack[1];
					stack_nxt[1] = stack[0];
				end
			end
			default: ;
		endcase
		tos_nxt            = (count_nxt == '0) ? '0 : stack_nxt[0]; // Empty reads as zero
		flags_nxt.zero     = (tos_nxt == '0);
		flags_nxt.negative = tos_nxt[15];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count        <= '0;
			flags        <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= cmd_valid && (cmd.op != op_push); // Push gets no reply
			if (cmd_valid) begin
				count <= count_nxt;
				flags <= flags_nxt;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid)
			stack <= stack_nxt;
	end

	assign tos   = (count == '0) ? '0 : stack[0];
	assign depth = 3'(count);

	assert property (@(posedge clk) disable iff (!rst_n) count <= CW'(STACK_DEPTH))
		else $error("stack count above STACK_DEPTH");

endmodule

// File: hw/tx_result_ctrl.sv
`timescale 1ns/1ns

module tx_result_ctrl import uart_pkg::*, rpn_calc_pkg::*; #(
	parameter int INTER_BYTE_GAP = 1000
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       result_valid,
	input  calc_word_t result,
	input  logic       tx_busy,
	output logic       tx_start,
	output uart_byte_t tx_data
);

	localparam int GW = $clog2(INTER_BYTE_GAP + 1);

	typedef enum logic [1:0] {s_idle, s_send_high, s_gap, s_send_low} tx_state_e;

	tx_state_e     state;
	calc_word_t    pend;        // Newest result not yet started
	logic          pend_valid;
	uart_byte_t    low_byte;    // Held for the second byte
	logic [GW-1:0] gap_cnt;
	logic          busy_q, busy_fall;
	logic          have_word, load_high, load_low;
	calc_word_t    next_word;

	assign busy_fall = busy_q & ~tx_busy;
	assign have_word = result_valid | pend_valid;
	assign next_word = result_valid ? result : pend; // Fresh one wins

	always_comb begin
		load_high = 1'b0;
		load_low  = 1'b0;
		case (state)
			s_idle:     load_high = have_word & ~tx_busy;
			s_gap:      load_low  = (gap_cnt == GW'(INTER_BYTE_GAP - 1));
			s_send_low: load_high = have_word & busy_fall; // Back to back replies
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= s_idle;
			pend_valid <= 1'b0;
			gap_cnt    <= '0;
			busy_q     <= 1'b0;
			tx_start   <= 1'b0;
		end else begin
			busy_q   <= tx_busy;
			tx_start <= load_high | load_low;
			if (load_high)
				pend_valid <= 1'b0;
			else if (result_valid)
				pend_valid <= 1'b1;
			case (state)
				s_idle:      if (load_high) state <= s_send_high;
				s_send_high: if (busy_fall) begin
					gap_cnt <= GW'(1); // Gap starts on the falling edge
					state   <= s_gap;
				end
				s_gap: begin
					gap_cnt <= gap_cnt + 1'b1;
					if (load_low)
						state <= s_send_low;
				end
				s_send_low:  if (busy_fall) state <= load_high ? s_send_high : s_idle;
				default:     state <= s_idle;
			endcase
		end
	end

	// Byte registers
	always_ff @(posedge clk) begin
		if (result_valid)
			pend <= result;
		if (load_high) begin
			tx_data  <= next_word[15:8]; // MSB first
			low_byte <= next_word[7:0];
		end else if (load_low)
			tx_data <= low_byte;
	end

endmodule

// File: hw/seg_display.sv
`timescale 1ns/1ns

module seg_display import rpn_calc_pkg::*; #(
	parameter int SCAN_DIV = 100_000
) (
	input  logic       clk,
	input  logic       rst_n,
	input  calc_word_t value,
	output logic [6:0] segments, // gfedcba, active low
	output logic [7:0] an
);

	localparam int DW = $clog2(SCAN_DIV + 1);

	logic [DW-1:0] div_cnt;
	logic [1:0]    digit;   // Which of the four low digits is lit
	logic [3:0]    nibble;
	logic [6:0]    seg_nxt;

	assign nibble = value[digit*4 +: 4];

	// Hex glyphs
	always_comb begin
		case (nibble)
			4'h0: seg_nxt = 7'h40;
			4'h1: seg_nxt = 7'h79;
			4'h2: seg_nxt = 7'h24;
			4'h3: seg_nxt = 7'h30;
			4'h4: seg_nxt = 7'h19;
			4'h5: seg_nxt = 7'h12;
			4'h6: seg_nxt = 7'h02;
			4'h7: seg_nxt = 7'h78;
			4'h8: seg_nxt = 7'h00;
			4'h9: seg_nxt = 7'h10;
			4'ha: seg_nxt = 7'h08;
			4'hb: seg_nxt = 7'h03; // Lower case b
			4'hc: seg_nxt = 7'h46;
			4'hd: seg_nxt = 7'h21; // Lower case d
			4'he: seg_nxt = 7'h06;
			default: seg_nxt = 7'h0e;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt  <= '0;
			digit    <= '0;
			segments <= 7'h7f; // Blank
			an       <= 8'hff;
		end else begin
			if (div_cnt == DW'(SCAN_DIV - 1)) begin
				div_cnt <= '0;
				digit   <= digit + 1'b1;
			end else
				div_cnt <= div_cnt + 1'b1;
			segments <= seg_nxt;
			an       <= {4'hf, ~(4'b0001 << digit)}; // Upper four stay dark
		end
	end

endmodule

// File: hw/uart_calc_top.sv
`timescale 1ns/1ns

module uart_calc_top import uart_pkg::*, rpn_calc_pkg::*; #(
	parameter int CLK_FREQUENCY  = 100_000_000,
	parameter int BAUD_RATE      = 115200,
	parameter int FRAME_TIMEOUT  = 100_000,  // Clocks between push bytes
	parameter int INTER_BYTE_GAP = 1000,     // Clocks between reply bytes
	parameter int STACK_DEPTH    = 4,
	parameter int SCAN_DIV       = 100_000   // Clocks per display digit
) (
	input  logic        clk100mhz,
	input  logic        rst_n,
	input  logic        uart_rx,
	output logic        uart_tx,
	output logic        uart_tx_busy,
	output logic        rx_ready,
	output logic [15:0] led,
	output logic [6:0]  segments,
	output logic [7:0]  an
);

	uart_byte_t  rx_data, tx_data;
	logic        tx_start;
	calc_cmd_t   cmd;
	logic        cmd_valid, result_valid;
	logic [3:0]  rx_state;
	calc_word_t  tos;
	calc_flags_t flags;
	logic [2:0]  depth;

	////////////////////
	// Receive path
	////////////////////
	uart_rx #(.CLK_FREQUENCY(CLK_FREQUENCY), .BAUD_RATE(BAUD_RATE)) u_rx (
		.clk(clk100mhz), .rst_n(rst_n), .rx(uart_rx), .rx_data(rx_data), .rx_ready(rx_ready)
	);

	rx_frame_ctrl #(.FRAME_TIMEOUT(FRAME_TIMEOUT)) u_frame (
		.clk(clk100mhz), .rst_n(rst_n), .rx_data(rx_data), .rx_ready(rx_ready),
		.cmd(cmd), .cmd_valid(cmd_valid), .state(rx_state)
	);

	rpn_alu #(.STACK_DEPTH(STACK_DEPTH)) u_alu (
		.clk(clk100mhz), .rst_n(rst_n), .cmd(cmd), .cmd_valid(cmd_valid), .tos(tos),
		.flags(flags), .result_valid(result_valid), .depth(depth)
	);

	////////////////////
	// Reply path
	////////////////////
	tx_result_ctrl #(.INTER_BYTE_GAP(INTER_BYTE_GAP)) u_reply (
		.clk(clk100mhz), .rst_n(rst_n), .result_valid(result_valid), .result(tos),
		.tx_busy(uart_tx_busy), .tx_start(tx_start), .tx_data(tx_data)
	);

	uart_tx #(.CLK_FREQUENCY(CLK_FREQUENCY), .BAUD_RATE(BAUD_RATE)) u_tx (
		.clk(clk100mhz), .rst_n(rst_n), .tx_start(tx_start), .tx_data(tx_data),
		.tx(uart_tx), .tx_busy(uart_tx_busy)
	);

	seg_display #(.SCAN_DIV(SCAN_DIV)) u_disp (
		.clk(clk100mhz), .rst_n(rst_n), .value(tos), .segments(segments), .an(an)
	);

	// Frame state on top, then depth, command strobe and flags
	assign led = {rx_state, 1'b0, depth, 1'b0, cmd_valid, 2'b00, flags};

endmodule

// File: tests/tb_uart_calc.sv
`timescale 1ns/1ns

module tb_uart_calc;

	localparam int CLK_FREQUENCY  = 1_000_000;
	localparam int BAUD_RATE      = 100_000;
	localparam int BIT_CYCLES     = CLK_FREQUENCY / BAUD_RATE; // 10 clocks per bit
	localparam int FRAME_TIMEOUT  = 200;
	localparam int INTER_BYTE_GAP = 20;
	localparam int STACK_DEPTH    = 4;
	localparam int SCAN_DIV       = 8;
	localparam int REPLY_WAIT     = 600;       // Cycles allowed for one reply
	localparam int CYCLE_LIMIT    = 300 * 600; // Frames times cycles per frame

	// Opcode bytes as the host sends them
	localparam logic [7:0] OPC_PUSH = 8'h01;
	localparam logic [7:0] OPC_ADD  = 8'h02;
	localparam logic [7:0] OPC_SUB  = 8'h03;
	localparam logic [7:0] OPC_MUL  = 8'h04;
	localparam logic [7:0] OPC_AND  = 8'h05;
	localparam logic [7:0] OPC_OR   = 8'h06;
	localparam logic [7:0] OPC_XOR  = 8'h07;
	localparam logic [7:0] OPC_DROP = 8'h08;
	localparam logic [7:0] OPC_SWAP = 8'h09;

	// Frame FSM as shown on led[15:12]
	localparam logic [3:0] FRAME_IDLE      = 4'b0001;
	localparam logic [3:0] FRAME_WAIT_HIGH = 4'b0010;
	localparam logic [3:0] FRAME_WAIT_LOW  = 4'b0100;

	logic        clk;
	logic        rst_n;
	logic        host_tx;  // Host to DUT serial line
	logic        host_rx;  // DUT to host serial line
	logic        tx_busy;
	logic        rx_ready;
	logic [15:0] led;
	logic [6:0]  segments;
	logic [7:0]  an;

	integer seed = 76981;
	int     rnd;
	int     errs        = 0;
	int     checks      = 0;
	int     cycle_count = 0;
	int     bytes_sent  = 0;
	int     ready_count = 0;
	int     cmds_sent   = 0;  // Complete frames sent by the host
	int     cmd_count   = 0;  // cmd_valid pulses seen on led[6]

	logic [15:0] model_q[$];  // Reference stack, entry 0 on top
	logic        model_err   = 1'b0;
	logic        model_carry = 1'b0;
	logic [7:0]  reply_q[$];  // Bytes collected from the DUT

	uart_calc_top #(
		.CLK_FREQUENCY(CLK_FREQUENCY), .BAUD_RATE(BAUD_RATE), .FRAME_TIMEOUT(FRAME_TIMEOUT),
		.INTER_BYTE_GAP(INTER_BYTE_GAP), .STACK_DEPTH(STACK_DEPTH), .SCAN_DIV(SCAN_DIV)
	) uut (
		.clk100mhz(clk), .rst_n(rst_n), .uart_rx(host_tx), .uart_tx(host_rx),
		.uart_tx_busy(tx_busy), .rx_ready(rx_ready), .led(led), .segments(segments), .an(an)
	);

	always #50 clk = ~clk; // 100 ns period

	// Run limit
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("Checks: %0d, errors: %0d, bytes sent: %0d", checks, errs, bytes_sent);
			$display("Test failed");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (rst_n && rx_ready)
			ready_count++; // One pulse per received byte
		if (rst_n && led[6])
			cmd_count++;   // One pulse per complete frame
	end

	////////////////////
	// Host receiver
	////////////////////
	initial begin : reply_monitor
		logic [7:0] data;
		forever begin
			@(negedge clk);
			if (rst_n && host_rx === 1'b0) begin
				repeat (BIT_CYCLES / 2 - 1) @(negedge clk); // Middle of start bit
				for (int i = 0; i < 8; i++) begin
					repeat (BIT_CYCLES) @(negedge clk);
					data[i] = host_rx; // LSB first
					checks++;
					assert (tx_busy === 1'b1) else begin
						errs++;
						$display("ERR %0t ns: uart_tx_busy was low during a reply byte", $time);
					end
				end
				repeat (BIT_CYCLES) @(negedge clk);
				checks++;
				assert (host_rx === 1'b1 && tx_busy === 1'b1) else begin
					errs++;
					$display("ERR %0t ns: reply byte had a bad stop bit or idle busy", $time);
				end
				reply_q.push_back(data);
			end
		end
	end

	////////////////////
	// Reference model
	////////////////////
	function automatic logic [15:0] model_tos();
		return (model_q.size() == 0) ? 16'h0000 : model_q[0]; // Empty reads as zero
	endfunction

	function automatic logic [3:0] model_flags();
		logic [15:0] t;
		t = model_tos();
		return {model_err, model_carry, t[15], t == 16'h0000};
	endfunction

	// Active low gfedcba pattern of one hex digit
	function automatic logic [6:0] hex_glyph(input logic [3:0] nib);
		logic [6:0] on;
		case (nib)
			4'h0: on = 7'b0111111;
			4'h1: on = 7'b0000110;
			4'h2: on = 7'b1011011;
			4'h3: on = 7'b1001111;
			4'h4: on = 7'b1100110;
			4'h5: on = 7'b1101101;
			4'h6: on = 7'b1111101;
			4'h7: on = 7'b0000111;
			4'h8: on = 7'b1111111;
			4'h9: on = 7'b1101111;
			4'ha: on = 7'b1110111;
			4'hb: on = 7'b1111100;
			4'hc: on = 7'b0111001;
			4'hd: on = 7'b1011110;
			4'he: on = 7'b1111001;
			default: on = 7'b1110001;
		endcase
		return ~on;
	endfunction

	task automatic model_apply(input logic [7:0] op, input logic [15:0] operand);
		logic [15:0] top, second, res;
		if (op >= OPC_PUSH && op <= OPC_SWAP)
			model_carry = 1'b0;
		case (op)
			OPC_PUSH: begin
				if (model_q.size() == STACK_DEPTH)
					res = model_q.pop_back(); // Oldest entry is lost
				model_q.push_front(operand);
				model_err = 1'b0;
			end
			OPC_ADD, OPC_SUB, OPC_MUL, OPC_AND, OPC_OR, OPC_XOR: begin
				if (model_q.size() < 2)
					model_err = 1'b1; // Stack stays as it is
				else begin
					top    = model_q.pop_front();
					second = model_q.pop_front();
					case (op)
						OPC_ADD: begin
							res         = second + top;
							model_carry = (res < top); // Sum wrapped past 16 bits
						end
						OPC_SUB: begin
							res         = second - top;
							model_carry = (second < top); // Borrow
						end
						OPC_MUL: res = second * top;
						OPC_AND: res = second & top;
						OPC_OR:  res = second | top;
						default: res = second ^ top;
					endcase
					model_q.push_front(res);
					model_err = 1'b0;
				end
			end
			OPC_DROP: begin
				model_err = (model_q.size() < 1);
				if (!model_err)
					res = model_q.pop_front();
			end
			OPC_SWAP: begin
				model_err = (model_q.size() < 2);
				if (!model_err) begin
					top    = model_q.pop_front();
					second = model_q.pop_front();
					model_q.push_front(top);
					model_q.push_front(second);
				end
			end
			default: ; // Never reaches the ALU
		endcase
	endtask

	////////////////////
	// Host side tasks
	////////////////////
	task automatic compare_value(input string what, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			errs++;
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Watch one full scan of the four low digits
	task automatic check_display();
		logic [3:0]  seen;
		logic [15:0] shown;
		int          d;
		seen  = 4'h0;
		shown = model_tos();
		for (int c = 0; c < 4 * SCAN_DIV; c++) begin
			@(posedge clk);
			#1;
			d = -1;
			for (int k = 0; k < 4; k++)
				if (an == ~(8'h01 << k))
					d = k; // Exactly one low anode, upper four dark
			checks++;
			assert (d >= 0) else begin
				errs++;
				$display("ERR %0t ns: anodes are %h, expected one lit low digit", $time, an);
			end
			if (d >= 0) begin
				seen[d] = 1'b1;
				compare_value($sformatf("segments of digit %0d", d), 16'(segments),
					16'(hex_glyph(shown[d*4 +: 4])));
			end
		end
		compare_value("scanned digits", 16'(seen), 16'h000f);
	endtask

	task automatic compare_leds();
		compare_value("flag LEDs", 16'(led[3:0]), 16'(model_flags()));
		compare_value("depth LEDs", 16'(led[10:8]), 16'(model_q.size()));
		compare_value("frame state LEDs", 16'(led[15:12]), 16'(FRAME_IDLE));
		compare_value("cmd_valid pulse count", 16'(cmd_count), 16'(cmds_sent));
		check_display();
	endtask

	task automatic send_byte(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0}; // Stop, data, start
		@(posedge clk);
		#1;
		for (int i = 0; i < 10; i++) begin
			host_tx = frame[i];
			repeat (BIT_CYCLES) @(posedge clk);
			#1;
		end
		bytes_sent++;
		compare_value("rx_ready pulse count", 16'(ready_count), 16'(bytes_sent));
	endtask

	task automatic run_push(input logic [15:0] value);
		send_byte(OPC_PUSH);
		send_byte(value[15:8]);
		send_byte(value[7:0]);
		cmds_sent++;
		model_apply(OPC_PUSH, value);
		repeat (2) @(posedge clk); // ALU settles, no reply expected
		#1;
		compare_leds();
	endtask

	task automatic run_op(input logic [7:0] op);
		logic [15:0] exp_tos;
		int          waited;
		send_byte(op);
		cmds_sent++;
		model_apply(op, 16'h0000);
		exp_tos = model_tos();
		waited  = 0;
		while (reply_q.size() < 2 && waited < REPLY_WAIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		checks++;
		assert (reply_q.size() >= 2) else begin
			errs++;
			$display("ERR %0t ns: no complete reply arrived for opcode %h", $time, op);
		end
		if (reply_q.size() >= 2) begin
			compare_value($sformatf("reply high byte, op %h", op), 16'(reply_q.pop_front()),
				16'(exp_tos[15:8]));
			compare_value($sformatf("reply low byte, op %h", op), 16'(reply_q.pop_front()),
				16'(exp_tos[7:0]));
		end
		compare_leds();
	endtask

	// Unknown opcode must be ignored
	task automatic expect_silence(input logic [7:0] op);
		send_byte(op);
		repeat (REPLY_WAIT) @(posedge clk);
		#1;
		checks++;
		assert (reply_q.size() == 0) else begin
			errs++;
			$display("ERR %0t ns: unknown opcode %h produced a reply", $time, op);
			reply_q.delete();
		end
		compare_leds();
	endtask

	task automatic abandon_push(input int data_bytes);
		send_byte(OPC_PUSH);
		if (data_bytes > 0) begin
			rnd = $random(seed);
			send_byte(rnd[7:0]);
		end
		compare_value("frame state LEDs", 16'(led[15:12]),
			16'((data_bytes > 0) ? FRAME_WAIT_LOW : FRAME_WAIT_HIGH));
		repeat (FRAME_TIMEOUT + 50) @(posedge clk); // Frame times out
		#1;
		compare_leds();
	endtask

	////////////////////
	// Test sequence
	////////////////////
	initial begin
		clk     = 1'b0;
		rst_n   = 1'b0;
		host_tx = 1'b1; // Line idles high
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (2) @(posedge clk);
		#1;

		// Arithmetic and logic ops on random operands
		run_push(16'hffff);
		run_push(16'h0001);
		run_op(OPC_ADD); // Carry out, zero result
		run_push(16'h0001);
		run_op(OPC_SUB); // Borrow, negative result
		for (int i = 0; i < 30; i++) begin
			rnd = $random(seed);
			run_push(rnd[15:0]);
			rnd = $random(seed);
			run_push(rnd[15:0]);
			rnd = $random(seed);
			run_op(OPC_ADD + 8'(rnd[7:0] % 6));
		end

		// Too few entries
		while (model_q.size() > 0)
			run_op(OPC_DROP);
		run_op(OPC_ADD);
		run_op(OPC_DROP);
		run_op(OPC_SWAP);
		rnd = $random(seed);
		run_push(rnd[15:0]);
		run_op(OPC_MUL);
		run_op(OPC_SWAP);
		rnd = $random(seed);
		run_push(rnd[15:0]);
		run_op(OPC_SUB); // Valid again, error clears

		// Overflow drops the oldest value
		while (model_q.size() > 0)
			run_op(OPC_DROP);
		for (int i = 0; i < 5; i++) begin
			rnd = $random(seed);
			run_push(rnd[15:0]);
		end
		run_op(OPC_XOR);
		run_op(OPC_ADD);
		run_op(OPC_MUL);
		run_op(OPC_ADD); // Single entry left
		// Drop and swap mix
		for (int i = 0; i < 24; i++) begin
			rnd = $random(seed);
			case (rnd[1:0])
				2'd0:    run_push(rnd[31:16]);
				2'd1:    run_op(OPC_DROP);
				default: run_op(OPC_SWAP);
			endcase
		end

		// Abandoned push frames and unknown opcodes
		abandon_push(0);
		run_op(OPC_SWAP);
		abandon_push(1);
		rnd = $random(seed);
		run_push(rnd[15:0]);
		run_op(OPC_OR);
		rnd = $random(seed);
		expect_silence(8'h0a + 8'(rnd[7:0] % 8'hf0));
		expect_silence(8'h00);
		run_op(OPC_AND);

		// Random traffic
		for (int i = 0; i < 60; i++) begin
			rnd = $random(seed);
			if (rnd[2:0] < 3'd3)
				run_push(rnd[31:16]);
			else
				run_op(OPC_ADD + 8'(rnd[10:8]));
		end

		repeat (REPLY_WAIT) @(posedge clk);
		compare_value("stray reply bytes", 16'(reply_q.size()), 16'h0000);
		compare_value("final rx_ready count", 16'(ready_count), 16'(bytes_sent));

		$display("Checks: %0d, errors: %0d, bytes sent: %0d", checks, errs, bytes_sent);
		if (errs == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: uart_calc_top.f
hw/uart_pkg.sv
hw/rpn_calc_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/rx_frame_ctrl.sv
hw/rpn_alu.sv
hw/tx_result_ctrl.sv
hw/seg_display.sv
hw/uart_calc_top.sv
tests/tb_uart_calc.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the calculator testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_uart_calc -f uart_calc_top.f \
	--Mdir obj_dir -o tb_uart_calc > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_uart_calc > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test completed successfully" "$SIM_LOG"; then
	exit 0
fi
exit 1
